// File: build.f
+incdir+verilog
verilog/conv_pkg.sv
verilog/lane_beat_if.sv
verilog/pad_filter.sv
verilog/lane_multiplier.sv
verilog/mask_accumulator.sv
verilog/row_conv_engine.sv
sim/row_conv_checker.sv
sim/row_conv_tb.sv

// File: sim/row_conv_tb.sv
`default_nettype none
`include "conv_cfg.svh"

module row_conv_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import conv_pkg::*;

    localparam int LANES   = `CONV_KERNEL_W_MAX;
    localparam int TIMEOUT = 200;                      // Cycles any single wait may take

    logic                            aclk;
    logic                            rst_n;
    logic                            in_valid;
    logic                            in_ready;
    logic signed [`CONV_PIXEL_W-1:0] in_pixel;
    conv_user_t                      in_user;
    logic                            out_valid;
    logic                            out_ready;
    logic signed [`CONV_ACC_W-1:0]   out_sum_full;
    logic signed [`CONV_ACC_W-1:0]   out_sum_partial;
    logic                            out_left;
    logic                            out_right;
    int errors;                                        // Driven by the checker
    int checked;
    int pending;
    int seed;
    bit bp_on;                                         // Random out_ready while set
    bit stuck;                                         // A wait ran out, skip further stimulus
    int tests_run;
    int tests_failed;
    int err_base;
    int chk_base;

    always #5 aclk = ~aclk;

    row_conv_engine uut (
        .aclk(aclk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
        .in_pixel(in_pixel), .in_user(in_user), .out_valid(out_valid),
        .out_ready(out_ready), .out_sum_full(out_sum_full),
        .out_sum_partial(out_sum_partial), .out_left(out_left), .out_right(out_right)
    );

    row_conv_checker chk (
        .aclk(aclk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready),
        .in_pixel(in_pixel), .in_user(in_user), .out_valid(out_valid),
        .out_ready(out_ready), .out_sum_full(out_sum_full),
        .out_sum_partial(out_sum_partial), .out_left(out_left), .out_right(out_right),
        .errors(errors), .checked(checked), .pending(pending)
    );

    function automatic conv_user_t make_user(input int kw1, input bit one, input bit cfg,
                                             input bit last, input bit cols);
        conv_user_t u;
        u.kernel_w_1   = kw1[KW_BITS-1:0];
        u.is_1x1       = one;
        u.is_config    = cfg;
        u.is_cin_last  = last;
        u.is_cols_1_k2 = cols;
        return u;
    endfunction

    task automatic drive_ready();
        int r;
        r = $random(seed);
        out_ready = bp_on ? (r[0] | r[1]) : 1'b1;      // About three cycles in four ready
    endtask

    // Present one beat on a falling edge and hold it until a rising edge accepts it
    task automatic send_beat(input int pixel, input conv_user_t u);
        int waited;
        int r;
        bit accepted;
        if (stuck)
            return;
        waited   = 0;
        accepted = 1'b0;
        r = $random(seed);
        if (r[2:0] == 0) begin
            @(negedge aclk);                           // Bubble between bursts
            in_valid = 1'b0;
            drive_ready();
        end
        @(negedge aclk);
        in_valid = 1'b1;
        in_pixel = pixel;
        in_user  = u;
        drive_ready();
        while (!accepted && waited < TIMEOUT) begin
            if (waited > 0) begin
                @(negedge aclk);
                drive_ready();
            end
            @(posedge aclk);
            accepted = in_ready;
            waited++;
        end
        if (!accepted) begin
            $display("ERROR at %0t ns: input beat was not accepted in time", $time);
            stuck = 1'b1;
        end
    endtask

    // Stop input and let every expected result come out, then report the test
    task automatic end_test(input string name);
        int waited;
        bit lost;
        waited = 0;
        @(negedge aclk);
        in_valid = 1'b0;
        while (pending != 0 && waited < TIMEOUT) begin
            drive_ready();
            @(negedge aclk);
            waited++;
        end
        lost = (pending != 0);
        if (lost)
            $display("ERROR at %0t ns: %0d expected results never came out", $time, pending);
        tests_run++;
        if (errors == err_base && !lost && !stuck) begin
            $display("test %0d %s passed with %0d results", tests_run, name, checked - chk_base);
        end else begin
            $display("test %0d %s failed with %0d errors", tests_run, name, errors - err_base);
            tests_failed++;
        end
        err_base = errors;
        chk_base = checked;
    endtask

    initial begin
        int r;
        aclk      = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_pixel  = '0;
        in_user   = '0;
        out_ready = 1'b1;
        seed      = 32'h5cb9_c29e;
        bp_on     = 1'b0;
        stuck     = 1'b0;
        tests_run = 0;
        tests_failed = 0;
        err_base  = 0;
        chk_base  = 0;
        repeat (10) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        for (int i = 0; i < LANES; i++)
            send_beat($random(seed), make_user(0, 0, 1, 0, 0)); // Fill every weight lane
        for (int i = 0; i < 8; i++)
            send_beat($random(seed), make_user(6, 1, 0, 0, 0)); // Widest kernel opens all lanes
        end_test("weight loading");
        for (int kw1 = 2; kw1 <= 6; kw1 += 2)
            for (int i = 0; i < 6; i++)
                send_beat($random(seed), make_user(kw1, 0, 0, 1, 0)); // Start bits clear out
        end_test("middle columns");
        for (int row = 0; row < 3; row++)
            for (int col = 0; col < 9; col++)
                for (int ch = 0; ch < 2; ch++)
                    send_beat($random(seed), make_user(2 + 2 * row, 0, 0, ch == 1,
                                                       col == 8 - (row + 1)));
        end_test("row edges");
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            send_beat($random(seed), make_user({r[1:0], 1'b0}, r[7:5] == 0, 0, r[2], r[3] & r[4]));
        end
        end_test("kernel changes");
        bp_on = 1'b1;
        for (int i = 0; i < 60; i++) begin
            r = $random(seed);
            send_beat($random(seed), make_user({r[1:0], 1'b0}, 0, r[6:4] == 0,
                                               r[6:4] != 0 && r[2], r[3]));
        end
        end_test("back-pressure");
        bp_on = 1'b0;
        $display("tests %0d, failed %0d, results checked %0d, errors %0d",
                 tests_run, tests_failed, checked, errors);
        if (errors == 0 && tests_failed == 0 && !stuck)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/row_conv_checker.sv
`default_nettype none
`include "conv_cfg.svh"

module row_conv_checker (
    input  logic                            aclk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  logic                            in_ready,
    input  logic signed [`CONV_PIXEL_W-1:0] in_pixel,
    input  conv_pkg::conv_user_t            in_user,
    input  logic                            out_valid,
    input  logic                            out_ready,
    input  logic signed [`CONV_ACC_W-1:0]   out_sum_full,
    input  logic signed [`CONV_ACC_W-1:0]   out_sum_partial,
    input  logic                            out_left,
    input  logic                            out_right,
    output int                              errors,
    output int                              checked,
    output int                              pending
);
    timeunit 1ns;
    timeprecision 1ps;
    import conv_pkg::*;

    localparam int LANES = `CONV_KERNEL_W_MAX;

    int weight [LANES];                                // Model weight chain, lane 0 newest
    bit end_bit [0:KW2_MAX];                           // Slot 0 stays clear for width 1
    bit start_bit [0:KW2_MAX];                         // Slot 0 stays clear as well
    bit left_reg;                                      // Left flag of the next column
    int exp_full [$];                                  // Expected results in accept order
    int exp_part [$];
    bit exp_left [$];
    bit exp_right [$];

    initial begin
        errors  = 0;
        checked = 0;
        pending = 0;
    end

    // Apply one accepted beat to the model using the state before the update
    task automatic model_beat(input int pixel, input conv_user_t u);
        int kw2;
        int sum_f;
        int sum_p;
        bit start_clear;
        bit stop;
        bit new_start;
        bit new_left;
        kw2 = u.kernel_w_1 / 2;
        if (u.is_config) begin
            for (int k = LANES - 1; k > 0; k--) begin
                weight[k] = weight[k-1];               // Weight chain moves one lane up
            end
            weight[0] = pixel;
        end else begin
            sum_f       = 0;
            sum_p       = 0;
            start_clear = 1'b1;
            for (int k = 1; k <= kw2; k++) begin
                if (start_bit[k])
                    start_clear = 1'b0;                // Still within the first kw2 columns
            end
            for (int w = 0; w < LANES; w++) begin
                if (u.is_1x1 || (kw2 != 0 && ((w == 2 * kw2 && start_clear) ||
                    (end_bit[kw2] && w >= kw2 && w <= 2 * kw2))))
                    sum_f += pixel * weight[w];
            end
            for (int w = 1; w < LANES; w++) begin
                stop = (w > 2 * kw2);                  // Lane lies outside the kernel
                if (w > kw2)
                    stop |= end_bit[kw2];
                else
                    for (int k = w; k <= kw2; k++)
                        stop |= end_bit[k];            // Lower lanes stop early near the row end
                if (!stop)
                    sum_p += pixel * weight[w];
            end
            exp_full.push_back(sum_f);
            exp_part.push_back(sum_p);
            exp_left.push_back(left_reg);
            exp_right.push_back(kw2 != 0 && end_bit[kw2]);
        end
        if (u.is_cin_last) begin
            new_start = end_bit[kw2];                  // Row end wraps into a row start
            new_left  = start_bit[kw2];
            for (int k = KW2_MAX; k > 1; k--) begin
                end_bit[k]   = end_bit[k-1];
                start_bit[k] = start_bit[k-1];
            end
            end_bit[1]   = u.is_cols_1_k2;
            start_bit[1] = new_start;
            left_reg     = new_left;
        end
    endtask

    always @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < LANES; k++)
                weight[k] = 0;
            for (int k = 0; k <= KW2_MAX; k++) begin
                end_bit[k]   = 1'b0;
                start_bit[k] = (k != 0);               // Every start bit set after reset
            end
            left_reg = 1'b1;
            exp_full.delete();
            exp_part.delete();
            exp_left.delete();
            exp_right.delete();
        end else begin
            if (out_valid && !out_ready && in_ready) begin
                $display("ERROR at %0t ns: in_ready is high while the output is stalled", $time);
                errors++;
            end
            if (out_valid && out_ready) begin
                if (exp_full.size() == 0) begin
                    $display("ERROR at %0t ns: a result came out with nothing expected", $time);
                    errors++;
                end else begin
                    if (int'(out_sum_full) != exp_full[0] || int'(out_sum_partial) != exp_part[0]
                        || out_left != exp_left[0] || out_right != exp_right[0]) begin
                        $display("[FAIL] %0t ns: result %0d expected full %0d partial %0d %s",
                                 $time, checked, exp_full[0], exp_part[0], "and flags");
                        $display("[FAIL] %0t ns: left %0b right %0b, got %0d %0d %0b %0b",
                                 $time, exp_left[0], exp_right[0], out_sum_full,
                                 out_sum_partial, out_left, out_right);
                        errors++;
                    end
                    void'(exp_full.pop_front());
                    void'(exp_part.pop_front());
                    void'(exp_left.pop_front());
                    void'(exp_right.pop_front());
                    checked++;
                end
            end
            if (in_valid && in_ready)
                model_beat(in_pixel, in_user);         // Result is at least a cycle away
            pending = exp_full.size();
        end
    end

endmodule

`default_nettype wire

// File: verilog/row_conv_engine.sv
`default_nettype none
`include "conv_cfg.svh"

module row_conv_engine (
    input  logic                            aclk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  logic signed [`CONV_PIXEL_W-1:0] in_pixel,
    input  conv_pkg::conv_user_t            in_user,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic signed [`CONV_ACC_W-1:0]   out_sum_full,
    output logic signed [`CONV_ACC_W-1:0]   out_sum_partial,
    output logic                            out_left,
    output logic                            out_right
);
    import conv_pkg::*;

    logic advance;                                     // Whole pipeline steps this cycle

    lane_beat_if #(.payload_t(lane_products_t)) prod_bus (); // Stage 1 products
    lane_beat_if #(.payload_t(lane_masks_t))    mask_bus (); // Stage 1 masks and flags

    // Output register empty or being drained, so every stage may shift
    assign advance        = !out_valid || out_ready;
    assign in_ready       = advance;
    assign prod_bus.clken = advance;
    assign mask_bus.clken = advance;

    lane_multiplier u_mult (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_pixel (in_pixel),
        .in_user  (in_user),
        .clken    (advance),
        .prod_bus (prod_bus)
    );

    pad_filter u_pad (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_user  (in_user),
        .clken    (advance),
        .mask_bus (mask_bus)
    );

    mask_accumulator u_acc (
        .aclk            (aclk),
        .rst_n           (rst_n),
        .prod_bus        (prod_bus),
        .mask_bus        (mask_bus),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_sum_full    (out_sum_full),
        .out_sum_partial (out_sum_partial),
        .out_left        (out_left),
        .out_right       (out_right)
    );

endmodule

`default_nettype wire

// File: verilog/mask_accumulator.sv
`default_nettype none
`include "conv_cfg.svh"

module mask_accumulator (
    input  logic                          aclk,
    input  logic                          rst_n,
    lane_beat_if.consumer                 prod_bus,
    lane_beat_if.consumer                 mask_bus,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic signed [`CONV_ACC_W-1:0] out_sum_full,
    output logic signed [`CONV_ACC_W-1:0] out_sum_partial,
    output logic                          out_left,
    output logic                          out_right
);
    localparam int LANES = `CONV_KERNEL_W_MAX;

    logic                          load;         // Stage 1 beat moves into the output
    logic signed [`CONV_ACC_W-1:0] sum_full;     // Sum of lanes with a full bit
    logic signed [`CONV_ACC_W-1:0] sum_partial;  // Sum of lanes with a partial bit

    // Mask stage valid matches the product stage, so only one is checked
    assign load = prod_bus.clken && prod_bus.valid && !prod_bus.user.is_config;

    always_comb begin
        sum_full    = '0;
        sum_partial = '0;
        for (int w = 0; w < LANES; w++) begin
            if (mask_bus.payload.full[w]) begin
                sum_full = sum_full + prod_bus.payload[w];       // Sign extends to the sum width
            end
        end
        for (int w = 1; w < LANES; w++) begin
            if (mask_bus.payload.partial[w]) begin
                sum_partial = sum_partial + prod_bus.payload[w];
            end
        end
    end

    // A config beat is dropped here, it only loaded weights
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;                       // New result replaces any taken one
        end else if (out_ready) begin
            out_valid <= 1'b0;                       // Taken and nothing follows
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            out_sum_full    <= sum_full;
            out_sum_partial <= sum_partial;
            out_left        <= mask_bus.payload.left;
            out_right       <= mask_bus.payload.right;
        end
    end

endmodule

`default_nettype wire

// File: verilog/lane_multiplier.sv
`default_nettype none
`include "conv_cfg.svh"

module lane_multiplier (
    input  logic                            aclk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  logic signed [`CONV_PIXEL_W-1:0] in_pixel,
    input  conv_pkg::conv_user_t            in_user,
    input  logic                            clken,
    lane_beat_if.producer                   prod_bus
);
    import conv_pkg::*;

    localparam int LANES = `CONV_KERNEL_W_MAX;

    logic signed [`CONV_WEIGHT_W-1:0] weight [LANES]; // Lane 0 holds the newest weight
    logic                             load;           // Accepted config beat
    lane_products_t                   prod_next;      // Products of the accepted beat

    assign load = in_valid && clken && in_user.is_config;

    // Config beats form a shift chain, seven beats fill every lane
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < LANES; k++) begin
                weight[k] <= '0;
            end
        end else if (load) begin
            weight[0] <= in_pixel;                    // Pixel field carries the weight
            for (int k = 1; k < LANES; k++) begin
                weight[k] <= weight[k-1];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < LANES; w++) begin
            prod_next[w] = in_pixel * weight[w];      // Signed, sized to the product width
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            prod_bus.valid <= 1'b0;
        end else if (clken) begin
            prod_bus.valid <= in_valid;               // Bubble in, bubble out
        end
    end

    always_ff @(posedge aclk) begin
        if (clken) begin
            prod_bus.user    <= in_user;              // Accumulator needs the config flag
            prod_bus.payload <= prod_next;
        end
    end

endmodule

`default_nettype wire

// File: verilog/pad_filter.sv
`default_nettype none
`include "conv_cfg.svh"

module pad_filter (
    input  logic                 aclk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  conv_pkg::conv_user_t in_user,
    input  logic                 clken,
    lane_beat_if.producer        mask_bus
);
    import conv_pkg::*;

    localparam int LANES = `CONV_KERNEL_W_MAX;

    logic [KW_BITS-2:0] kw2;                           // Kernel half, 3 for a 7 wide kernel
    logic               edge_en;                       // Column finished, shift the edge state
    logic [KW2_MAX:1]   col_end;                       // End marker travelling toward the edge
    logic [KW2_MAX:1]   col_start;                     // Start marker after the row wraps
    logic               col_left;                      // First column flag, one column late
    logic [KW2_MAX:0]   end_ext;                       // End bits with a cleared slot 0
    logic [KW2_MAX:0]   start_ext;                     // Start bits with a cleared slot 0
    logic               lut_full [LANES-1:0][KW2_MAX:0]; // Full allow per lane and kernel
    logic               lut_stop [LANES-1:1][KW2_MAX:0]; // Partial block per lane and kernel
    lane_masks_t        mask_next;                     // Masks of the beat being accepted

    assign kw2       = in_user.kernel_w_1[KW_BITS-1:1]; // Halving an even value drops bit 0
    assign edge_en   = in_valid && clken && in_user.is_cin_last;
    assign end_ext   = {col_end, 1'b0};                // A width 1 kernel reads a zero bit
    assign start_ext = {col_start, 1'b0};

    // Both markers move one place per finished column, so a kernel half k
    // sees the row end k columns after is_cols_1_k2 and the row start right after
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            col_end   <= '0;                           // No row end pending
            col_start <= '1;                           // The first row starts at reset
            col_left  <= 1'b1;                         // First column is a left edge
        end else if (edge_en) begin
            col_end[1]   <= in_user.is_cols_1_k2;      // New end marker enters
            col_start[1] <= end_ext[kw2];              // Row end wraps into a row start
            for (int k = 2; k <= KW2_MAX; k++) begin
                col_end[k]   <= col_end[k-1];
                col_start[k] <= col_start[k-1];
            end
            col_left <= start_ext[kw2];                // Start reached this kernel's tap
        end
    end

    // The full mask table covers every odd kernel so the width can change per beat
    for (genvar w = 0; w < LANES; w++) begin : g_full_lane
        assign lut_full[w][0] = 1'b0;                  // Width 1 without 1x1 blocks all lanes
        for (genvar k = 1; k <= KW2_MAX; k++) begin : g_full_kw2
            logic top_lane;
            logic in_start;
            logic at_end;
            assign top_lane = (w == 2 * k);            // Lane holding the complete window
            assign in_start = |col_start[k:1];         // Still inside the first k columns
            assign at_end   = col_end[k] && (w >= k) && (w <= 2 * k); // Padded windows at row end
            assign lut_full[w][k] = (top_lane && !in_start) || at_end;
        end
    end

    // Lane 0 never holds a partial window, so this table starts at lane 1
    for (genvar w = 1; w < LANES; w++) begin : g_part_lane
        assign lut_stop[w][0] = 1'b1;                  // Nothing passes for width 1
        for (genvar k = 1; k <= KW2_MAX; k++) begin : g_part_kw2
            logic end_hit;
            if (w > k) begin : g_outer
                assign end_hit = col_end[k];           // Upper lanes stop only at the last column
            end else begin : g_inner
                assign end_hit = |col_end[k:w];        // Lower lanes stop early, a triangle
            end
            assign lut_stop[w][k] = (w > 2 * k) || end_hit; // Lanes past the kernel are unused
        end
    end

    always_comb begin
        mask_next.full    = '0;
        mask_next.partial = '0;
        for (int w = 0; w < LANES; w++) begin
            mask_next.full[w] = lut_full[w][kw2] || in_user.is_1x1; // Pointwise passes all
        end
        for (int w = 1; w < LANES; w++) begin
            mask_next.partial[w] = !lut_stop[w][kw2];
        end
        mask_next.left  = col_left;                    // State before this beat's update
        mask_next.right = end_ext[kw2];                // Zero when kw2 is zero
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            mask_bus.valid <= 1'b0;
        end else if (clken) begin
            mask_bus.valid <= in_valid;                // Mirrors the product stage valid
        end
    end

    always_ff @(posedge aclk) begin
        if (clken) begin
            mask_bus.payload <= mask_next;
        end
    end

endmodule

`default_nettype wire

// File: verilog/lane_beat_if.sv
`default_nettype none

interface lane_beat_if #(
    parameter type payload_t = logic     // Product array or mask struct
) ();
    import conv_pkg::*;

    logic       valid;                   // Stage register holds a beat
    logic       clken;                   // Global advance from the top level
    conv_user_t user;                    // Sideband word of the held beat
    payload_t   payload;                 // Stage data proper

    // Stage 1 block that fills the register
    modport producer (output valid, input clken, output user, output payload);

    // The accumulator only reads
    modport consumer (input valid, input clken, input user, input payload);

endinterface

`default_nettype wire

// File: verilog/conv_pkg.sv
`default_nettype none
`include "conv_cfg.svh"

package conv_pkg;

    localparam int KW2_MAX = `CONV_KERNEL_W_MAX / 2;     // Kernel half positions, 7 gives 3
    localparam int KW_BITS = $clog2(`CONV_KERNEL_W_MAX); // Holds kernel width minus one

    typedef struct packed {
        logic [KW_BITS-1:0] kernel_w_1;   // Kernel width minus one, always even
        logic               is_1x1;       // Pointwise kernel, every lane counts
        logic               is_config;    // Beat carries a weight, not a pixel
        logic               is_cin_last;  // Last input channel of this column
        logic               is_cols_1_k2; // Column sits kernel half before row end
    } conv_user_t;

    typedef logic signed [`CONV_PIXEL_W+`CONV_WEIGHT_W-1:0] product_t; // Full precision product

    typedef product_t [`CONV_KERNEL_W_MAX-1:0] lane_products_t;        // One product per lane

    typedef struct packed {
        logic [`CONV_KERNEL_W_MAX-1:0] full;    // Lanes that enter the full sum
        logic [`CONV_KERNEL_W_MAX-1:1] partial; // Lanes that enter the partial sum
        logic                          left;    // First column of the row
        logic                          right;   // Last column of the row
    } lane_masks_t;

endpackage

`default_nettype wire

// File: verilog/conv_cfg.svh
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// Largest odd kernel width the engine handles, one multiplier lane per column
`define CONV_KERNEL_W_MAX 7

// Signed pixel width on the input stream
`define CONV_PIXEL_W 8

// Signed weight width held in each lane
`define CONV_WEIGHT_W 8

// Signed sum width, wide enough for seven full 16 bit products
`define CONV_ACC_W 19

`endif
